/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cw_target_ctrl
FILELIST = verilog.f
LOG      = sim.log

SRCS = $(shell cat $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* cw_cfg_if.sv */
`timescale 1ns/1ps

interface cw_cfg_if;
   import cw_pkg::*;

   reg_byte_t trigsrc;                             // trigger source enables and mode
   reg_byte_t trigmod;                             // trigger module select
   route_t    route;                               // gpio, extra and xgpio routing

   modport regs (
      output trigsrc,
      output trigmod,
      output route
   );

   modport trig (
      input trigsrc,
      input trigmod
   );

   modport io (
      input route
   );

   modport pwr (
      input route
   );

endinterface

/* cw_io_router.sv */
`timescale 1ns/1ps

module cw_io_router (
   cw_cfg_if.io            cfg,
   input  logic            io_highz,
   input  logic            uart_tx_i,
   input  logic            usi_out_i,
   input  cw_pkg::io_vec_t targetio_i,
   output cw_pkg::io_vec_t targetio_o,
   output cw_pkg::io_vec_t targetio_oe_o,
   output logic            uart_rx_o,
   output logic            usi_in_o,
   output logic            enable_avrprog_o,
   output logic            enable_output_nrst_o,
   output logic            output_nrst_o,
   output logic            enable_output_pdid_o,
   output logic            output_pdid_o,
   output logic            enable_output_pdic_o,
   output logic            output_pdic_o
);
   import cw_pkg::*;

   reg_byte_t gp [IO_LINES];                       // per line routing byte
   reg_byte_t extra;
   reg_byte_t xgpio;

   assign gp[0] = cfg.route[BYTE_GPIO1*8 +: 8];
   assign gp[1] = cfg.route[BYTE_GPIO2*8 +: 8];
   assign gp[2] = cfg.route[BYTE_GPIO3*8 +: 8];
   assign gp[3] = cfg.route[BYTE_GPIO4*8 +: 8];
   assign extra = cfg.route[BYTE_EXTRA*8 +: 8];
   assign xgpio = cfg.route[BYTE_XGPIO*8 +: 8];

   // {oe, out} of one line, first set bit wins
   function automatic logic [1:0] line_drive(reg_byte_t g, logic tx, logic uso,
                                             logic has_usio, logic has_oc);
      logic [1:0] drv;
      if (g[GP_TX]) drv = {1'b1, tx};
      else if (has_usio && g[GP_USIO]) drv = {1'b1, uso};
      else if (has_oc && g[GP_USOC]) drv = {~uso, 1'b0};  // pull low only
      else if (has_oc && g[GP_TXO]) drv = {~tx, 1'b0};
      else if (g[GP_EN]) drv = {1'b1, g[GP_VAL]};          // static level
      else drv = 2'b00;                                    // not driven
      return drv;
   endfunction

   always_comb begin
      logic [1:0] drv;
      for (int i = 0; i < IO_LINES; i++) begin
         drv = line_drive(gp[i], uart_tx_i, usi_out_i, i < 3, i == 2);
         targetio_o[i]    = drv[0];
         targetio_oe_o[i] = drv[1] & ~io_highz;   // all off while unpowered
      end
   end

   // input steering, lowest line written last so it wins
   always_comb begin
      uart_rx_o = 1'b1;                            // idle high
      for (int i = IO_LINES - 1; i >= 0; i--) begin
         if (gp[i][GP_RX]) uart_rx_o = targetio_i[i];
      end
      usi_in_o = 1'b1;
      for (int i = 2; i >= 0; i--) begin           // lines 1 to 3 only
         if (gp[i][GP_USII]) usi_in_o = targetio_i[i];
      end
   end

   assign enable_avrprog_o     = extra[EX_AVRPROG];
   assign enable_output_nrst_o = xgpio[0];
   assign output_nrst_o        = xgpio[1];
   assign enable_output_pdid_o = xgpio[2];
   assign output_pdid_o        = xgpio[3];
   assign enable_output_pdic_o = xgpio[4];
   assign output_pdic_o        = xgpio[5];

endmodule

/* cw_pkg.sv */
package cw_pkg;

   localparam int IO_LINES = 4;                    // target io lines on the rear header
   localparam int ROUTE_BYTES = 8;                 // bytes in the routing register

   typedef logic [5:0] reg_addr_t;                 // register bus address
   typedef logic [7:0] reg_byte_t;                 // one bus data byte
   typedef logic [6:0] bytecnt_t;                  // byte index in a multi-byte register
   typedef logic [IO_LINES-1:0] io_vec_t;          // one bit per target io line
   typedef logic [ROUTE_BYTES*8-1:0] route_t;      // whole routing register

   typedef enum logic [1:0] {
      PWR_OFF,                                     // power off or no soft start pending
      PWR_RAMP,                                    // pwm soft start running
      PWR_ON                                       // soft start done
   } power_state_t;

   localparam reg_addr_t ADDR_TRIGSRC = 6'd39;     // external trigger source
   localparam reg_addr_t ADDR_TRIGMOD = 6'd40;     // trigger module select
   localparam reg_addr_t ADDR_IOROUTE = 6'd55;     // 8 byte routing block
   localparam reg_addr_t ADDR_IOREAD  = 6'd59;     // pad snapshot, read only

   localparam reg_byte_t TRIGSRC_RESET = 8'b0010_0000;          // line 4 only, or mode
   localparam route_t    IOROUTE_RESET = 64'h0000_0000_0000_0201; // gpio1 tx, gpio2 rx

   localparam int BYTE_GPIO1  = 0;
   localparam int BYTE_GPIO2  = 1;
   localparam int BYTE_GPIO3  = 2;
   localparam int BYTE_GPIO4  = 3;
   localparam int BYTE_GLITCH = 4;                 // glitch enables, storage only
   localparam int BYTE_EXTRA  = 5;                 // avr prog and target power
   localparam int BYTE_XGPIO  = 6;                 // nrst, pdid, pdic pins

   localparam int GP_TX   = 0;                     // drive line from uart tx
   localparam int GP_RX   = 1;                     // line feeds uart rx
   localparam int GP_USIO = 2;                     // drive line from usi out
   localparam int GP_USII = 3;                     // line feeds usi in
   localparam int GP_USOC = 4;                     // usi out open collector, line 3
   localparam int GP_TXO  = 5;                     // uart tx open collector, line 3
   localparam int GP_VAL  = 6;                     // static gpio level
   localparam int GP_EN   = 7;                     // static gpio enable

   localparam int EX_AVRPROG   = 0;
   localparam int EX_PWROFF    = 1;                // 1 = target power off
   localparam int EX_FASTSTART = 2;                // 1 = skip pwm soft start

   localparam int TRIGSRC_LINE0 = 2;               // enable bit of trigger line 1
   localparam int TRIGSRC_MODE  = 6;               // lsb of combine mode field

   localparam logic [1:0] COMB_OR   = 2'b00;
   localparam logic [1:0] COMB_AND  = 2'b01;
   localparam logic [1:0] COMB_NAND = 2'b10;

   localparam logic [2:0] TMOD_EXT     = 3'b000;   // combined external lines
   localparam logic [2:0] TMOD_ADVIO   = 3'b001;
   localparam logic [2:0] TMOD_ANAPAT  = 3'b010;
   localparam logic [2:0] TMOD_DECODED = 3'b011;

endpackage

/* cw_reg_file.sv */
`timescale 1ns/1ps

module cw_reg_file (
   input  logic              clk_usb,
   input  logic              reset,
   input  cw_pkg::reg_addr_t reg_address_i,
   input  cw_pkg::bytecnt_t  reg_bytecnt_i,
   input  cw_pkg::reg_byte_t reg_datai_i,
   input  logic              reg_read_i,
   input  logic              reg_write_i,
   input  cw_pkg::io_vec_t   targetio_i,
   output cw_pkg::reg_byte_t reg_datao_o,
   cw_cfg_if.regs            cfg
);
   import cw_pkg::*;

   reg_byte_t   trigsrc_q;                         // trigger source byte
   reg_byte_t   trigmod_q;                         // trigger module byte
   route_t      route_q;                           // routing bytes 0..7
   io_vec_t     ioread_q;                          // pad snapshot
   logic [2:0]  byte_sel;                          // routing byte within range
   logic        byte_ok;                           // bytecnt below ROUTE_BYTES
   logic [5:0]  byte_lsb;                          // bit offset of selected byte

   assign byte_sel = reg_bytecnt_i[2:0];
   assign byte_ok  = reg_bytecnt_i < ROUTE_BYTES;
   assign byte_lsb = {byte_sel, 3'b000};

   // configuration to the function blocks
   assign cfg.trigsrc = trigsrc_q;
   assign cfg.trigmod = trigmod_q;
   assign cfg.route   = route_q;

   // bus writes, effective next cycle
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         trigsrc_q <= TRIGSRC_RESET;
         trigmod_q <= '0;                          // external trigger path
         route_q   <= IOROUTE_RESET;
      end else if (reg_write_i) begin
         case (reg_address_i)
            ADDR_TRIGSRC: trigsrc_q <= reg_datai_i;
            ADDR_TRIGMOD: trigmod_q <= reg_datai_i;
            ADDR_IOROUTE: begin
               if (byte_ok) begin
                  route_q[byte_lsb +: 8] <= reg_datai_i;   // one routing byte
               end
            end
            default: ;                             // read only or unmapped
         endcase
      end
   end

   // pads sampled every cycle
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ioread_q <= '0;
      end else begin
         ioread_q <= targetio_i;
      end
   end

   // registered read data, zero when not reading
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         reg_datao_o <= '0;
      end else if (reg_read_i) begin
         case (reg_address_i)
            ADDR_TRIGSRC: reg_datao_o <= trigsrc_q;
            ADDR_TRIGMOD: reg_datao_o <= trigmod_q;
            ADDR_IOROUTE: begin
               if (byte_ok) begin
                  reg_datao_o <= route_q[byte_lsb +: 8];
               end else begin
                  reg_datao_o <= '0;               // byte 8 and up reads as 0
               end
            end
            ADDR_IOREAD: reg_datao_o <= {4'b0000, ioread_q};
            default: reg_datao_o <= '0;            // unknown address
         endcase
      end else begin
         reg_datao_o <= '0;
      end
   end

endmodule

/* cw_target_ctrl.sv */
`timescale 1ns/1ps

module cw_target_ctrl #(
   parameter int PWM_W        = 11,                // soft start pwm width
   parameter int PWM_ON_COUNT = 1400,              // off phase per pwm period
   parameter int STEP_W       = 14                 // soft start period count width
) (
   input  logic              clk_usb,
   input  logic              reset,
   input  cw_pkg::reg_addr_t reg_address_i,
   input  cw_pkg::bytecnt_t  reg_bytecnt_i,
   input  cw_pkg::reg_byte_t reg_datai_i,
   input  logic              reg_read_i,
   input  logic              reg_write_i,
   input  cw_pkg::io_vec_t   trigger_io_i,
   input  logic              trigger_advio_i,
   input  logic              trigger_decodedio_i,
   input  logic              trigger_anapattern_i,
   input  logic              uart_tx_i,
   input  logic              usi_out_i,
   input  cw_pkg::io_vec_t   targetio_i,
   output cw_pkg::reg_byte_t reg_datao_o,
   output logic              trigger_o,
   output logic              trigger_ext_o,
   output logic              led_auxi_o,
   output logic              led_auxo_o,
   output cw_pkg::io_vec_t   targetio_o,
   output cw_pkg::io_vec_t   targetio_oe_o,
   output logic              uart_rx_o,
   output logic              usi_in_o,
   output logic              enable_avrprog_o,
   output logic              enable_output_nrst_o,
   output logic              output_nrst_o,
   output logic              enable_output_pdid_o,
   output logic              output_pdid_o,
   output logic              enable_output_pdic_o,
   output logic              output_pdic_o,
   output logic              targetpower_off_o
);

   logic io_highz;                                 // target unpowered, pads released

   cw_cfg_if cfg_i ();                             // shared configuration

   cw_reg_file reg_file_i (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_address_i (reg_address_i),
      .reg_bytecnt_i (reg_bytecnt_i),
      .reg_datai_i   (reg_datai_i),
      .reg_read_i    (reg_read_i),
      .reg_write_i   (reg_write_i),
      .targetio_i    (targetio_i),
      .reg_datao_o   (reg_datao_o),
      .cfg           (cfg_i.regs)
   );

   cw_trigger_mux trigger_mux_i (
      .cfg                  (cfg_i.trig),
      .trigger_io_i         (trigger_io_i),
      .trigger_advio_i      (trigger_advio_i),
      .trigger_decodedio_i  (trigger_decodedio_i),
      .trigger_anapattern_i (trigger_anapattern_i),
      .trigger_o            (trigger_o),
      .trigger_ext_o        (trigger_ext_o),
      .led_auxi_o           (led_auxi_o),
      .led_auxo_o           (led_auxo_o)
   );

   cw_io_router io_router_i (
      .cfg                  (cfg_i.io),
      .io_highz             (io_highz),
      .uart_tx_i            (uart_tx_i),
      .usi_out_i            (usi_out_i),
      .targetio_i           (targetio_i),
      .targetio_o           (targetio_o),
      .targetio_oe_o        (targetio_oe_o),
      .uart_rx_o            (uart_rx_o),
      .usi_in_o             (usi_in_o),
      .enable_avrprog_o     (enable_avrprog_o),
      .enable_output_nrst_o (enable_output_nrst_o),
      .output_nrst_o        (output_nrst_o),
      .enable_output_pdid_o (enable_output_pdid_o),
      .output_pdid_o        (output_pdid_o),
      .enable_output_pdic_o (enable_output_pdic_o),
      .output_pdic_o        (output_pdic_o)
   );

   cw_target_power #(
      .PWM_W        (PWM_W),
      .PWM_ON_COUNT (PWM_ON_COUNT),
      .STEP_W       (STEP_W)
   ) target_power_i (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .cfg               (cfg_i.pwr),
      .targetpower_off_o (targetpower_off_o),
      .io_highz          (io_highz)
   );

endmodule

/* cw_target_ctrl_sva.sv */
`timescale 1ns/1ps

module cw_target_ctrl_sva (
   input logic              clk_usb,
   input logic              reset,
   input logic              reg_read_i,
   input cw_pkg::reg_byte_t reg_datao_o,
   input cw_pkg::io_vec_t   targetio_oe_o,
   input logic              targetpower_off_o,
   input cw_pkg::route_t    route
);
   import cw_pkg::*;

   logic pwroff_cfg;                               // power-off bit in the routing register

   assign pwroff_cfg = route[BYTE_EXTRA*8 + EX_PWROFF];

   // read data is zero the cycle after no read
   assert property (@(posedge clk_usb) disable iff (reset)
      !reg_read_i |=> reg_datao_o == '0)
      else $error("read data not zero after idle cycle");

   // off bit reaches the pins a cycle later, pads released
   assert property (@(posedge clk_usb) disable iff (reset)
      $past(pwroff_cfg) |-> (targetpower_off_o && targetio_oe_o == '0))
      else $error("target powered or pads driven while power off is set");

   // power comes up on after reset
   assert property (@(posedge clk_usb)
      ($past(reset) && !reset) |-> !targetpower_off_o)
      else $error("target power off right after reset");

endmodule

bind cw_target_ctrl cw_target_ctrl_sva sva_i (
   .clk_usb           (clk_usb),
   .reset             (reset),
   .reg_read_i        (reg_read_i),
   .reg_datao_o       (reg_datao_o),
   .targetio_oe_o     (targetio_oe_o),
   .targetpower_off_o (targetpower_off_o),
   .route             (cfg_i.route)
);

/* cw_target_power.sv */
`timescale 1ns/1ps

module cw_target_power #(
   parameter int PWM_W        = 11,
   parameter int PWM_ON_COUNT = 1400,
   parameter int STEP_W       = 14
) (
   input  logic   clk_usb,
   input  logic   reset,
   cw_cfg_if.pwr  cfg,
   output logic   targetpower_off_o,
   output logic   io_highz
);
   import cw_pkg::*;

   logic              off_q;                       // registered power-off bit
   logic              off_prev_q;                  // for switch-on edge
   logic              fast_start;
   logic [PWM_W-1:0]  pwm_cnt;                     // position in pwm period
   logic [STEP_W-1:0] step_cnt;                    // pwm periods done
   power_state_t      state;

   assign fast_start = cfg.route[BYTE_EXTRA*8 + EX_FASTSTART];

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         off_q      <= 1'b0;
         off_prev_q <= 1'b0;
         state      <= PWR_OFF;
         pwm_cnt    <= '0;
         step_cnt   <= '0;
      end else begin
         off_q      <= cfg.route[BYTE_EXTRA*8 + EX_PWROFF];
         off_prev_q <= off_q;
         pwm_cnt    <= (state == PWR_RAMP) ? pwm_cnt + 1'b1 : '0;   // runs only in ramp
         if (off_q) begin
            state    <= PWR_OFF;
            step_cnt <= '0;
         end else begin
            case (state)
               PWR_OFF: if (off_prev_q) state <= PWR_RAMP;          // switched on
               PWR_RAMP: begin
                  if (&pwm_cnt) begin
                     step_cnt <= step_cnt + 1'b1;
                     if (&step_cnt) state <= PWR_ON;                // last period done
                  end
               end
               default: state <= PWR_ON;
            endcase
         end
      end
   end

   // off during the early part of each period, and always once the off bit is in
   assign targetpower_off_o = off_q |
                              (state == PWR_RAMP && !fast_start && pwm_cnt < PWM_ON_COUNT);
   assign io_highz = off_q;

endmodule

/* cw_trigger_mux.sv */
`timescale 1ns/1ps

module cw_trigger_mux (
   cw_cfg_if.trig          cfg,
   input  cw_pkg::io_vec_t trigger_io_i,
   input  logic            trigger_advio_i,
   input  logic            trigger_decodedio_i,
   input  logic            trigger_anapattern_i,
   output logic            trigger_o,
   output logic            trigger_ext_o,
   output logic            led_auxi_o,
   output logic            led_auxo_o
);
   import cw_pkg::*;

   io_vec_t line_en;                               // per line source enable
   logic    trig_or;                               // 0 with no line enabled
   logic    trig_and;                              // 1 with no line enabled

   assign line_en  = cfg.trigsrc[TRIGSRC_LINE0 +: IO_LINES];
   assign trig_or  = |(line_en & trigger_io_i);
   assign trig_and = &(~line_en | trigger_io_i);   // disabled lines count as 1

   always_comb begin
      case (cfg.trigsrc[TRIGSRC_MODE +: 2])
         COMB_OR:   trigger_ext_o = trig_or;
         COMB_AND:  trigger_ext_o = trig_and;
         COMB_NAND: trigger_ext_o = ~trig_and;
         default:   trigger_ext_o = 1'b0;          // fourth mode unused
      endcase
   end

   // capture trigger select
   always_comb begin
      case (cfg.trigmod[2:0])
         TMOD_EXT:     trigger_o = trigger_ext_o;
         TMOD_ADVIO:   trigger_o = trigger_advio_i;
         TMOD_ANAPAT:  trigger_o = trigger_anapattern_i;
         TMOD_DECODED: trigger_o = trigger_decodedio_i;
         default:      trigger_o = 1'b0;
      endcase
   end

   assign led_auxi_o = cfg.trigsrc[0];             // front panel a source bit
   assign led_auxo_o = cfg.trigmod[3];             // trigger out to front panel

endmodule

/* tb_cw_target_ctrl.sv */
`timescale 1ns/1ps

module tb_cw_target_ctrl;
   import cw_pkg::*;

   localparam int N_TRIG = 24;                     // random trigger rounds

   typedef struct packed {
      logic [2:0]  kind;
      logic [5:0]  addr;
      logic [6:0]  bcnt;
      logic [7:0]  data;
      logic [15:0] exp;
   } step_t;

   localparam logic [2:0] K_WR = 3'd0, K_RD = 3'd1, K_IO = 3'd2;
   localparam logic [2:0] K_PIN = 3'd3, K_PWR = 3'd4, K_RAMP = 3'd5;

   logic clk_usb = 1'b0;
   logic reset;
   reg_addr_t reg_address_i;
   bytecnt_t reg_bytecnt_i;
   reg_byte_t reg_datai_i, reg_datao_o;
   logic reg_read_i, reg_write_i;
   io_vec_t trigger_io_i, targetio_i, targetio_o, targetio_oe_o;
   logic trigger_advio_i, trigger_decodedio_i, trigger_anapattern_i, uart_tx_i, usi_out_i;
   logic trigger_o, trigger_ext_o, led_auxi_o, led_auxo_o, uart_rx_o, usi_in_o;
   logic enable_avrprog_o, enable_output_nrst_o, output_nrst_o, enable_output_pdid_o;
   logic output_pdid_o, enable_output_pdic_o, output_pdic_o, targetpower_off_o;

   step_t steps[$];
   string names[$];
   int errors = 0;
   int tests = 0;
   int cycles = 0;
   int cycle_limit = 100000;                       // narrowed once the table is built

   cw_target_ctrl #(.PWM_W(4), .PWM_ON_COUNT(6), .STEP_W(3)) dut_i (.*);

   always #10 clk_usb = ~clk_usb;

   always @(posedge clk_usb) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("run stopped, cycle limit of %0d reached", cycle_limit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic check(string name, logic [15:0] exp, logic [15:0] act);
      if (exp !== act) begin
         $display("error %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic add(string n, logic [2:0] k, logic [5:0] a, logic [6:0] b,
                      logic [7:0] d, logic [15:0] e);
      steps.push_back('{kind: k, addr: a, bcnt: b, data: d, exp: e});
      names.push_back(n);
   endtask

   task automatic bus_write(logic [5:0] a, logic [6:0] b, logic [7:0] d);
      @(posedge clk_usb);
      reg_write_i   <= 1'b1;
      reg_address_i <= a;
      reg_bytecnt_i <= b;
      reg_datai_i   <= d;
      @(posedge clk_usb);
      reg_write_i   <= 1'b0;                       // config live after this edge
   endtask

   // reference for the external trigger combine rules
   function automatic logic comb_model(io_vec_t en, io_vec_t lines, logic [1:0] mode);
      logic any_v;
      logic all_v;
      any_v = 1'b0;
      all_v = 1'b1;
      for (int i = 0; i < 4; i++) begin
         if (en[i]) begin
            any_v = any_v | lines[i];
            all_v = all_v & lines[i];
         end
      end
      if (mode == 2'd0) return any_v;
      if (mode == 2'd1) return all_v;
      if (mode == 2'd2) return ~all_v;
      return 1'b0;
   endfunction

   task automatic apply(step_t s, string name);
      int e0;
      bit seen_high;
      int low_run;
      e0 = errors;
      case (s.kind)
         K_WR: bus_write(s.addr, s.bcnt, s.data);
         K_RD: begin
            @(posedge clk_usb);
            reg_read_i    <= 1'b1;
            reg_address_i <= s.addr;
            reg_bytecnt_i <= s.bcnt;
            @(posedge clk_usb);
            reg_read_i    <= 1'b0;
            @(negedge clk_usb);                    // data one cycle after strobe
            check(name, s.exp, {8'h00, reg_datao_o});
         end
         K_IO: begin
            @(posedge clk_usb);
            uart_tx_i  <= s.data[0];
            usi_out_i  <= s.data[1];
            targetio_i <= s.data[7:4];
            @(posedge clk_usb);
            @(negedge clk_usb);
            check(name, s.exp, {6'd0, usi_in_o, uart_rx_o, targetio_oe_o,
                                targetio_o & targetio_oe_o});   // undriven out ignored
         end
         K_PIN: begin
            @(negedge clk_usb);
            check(name, s.exp, {9'd0, enable_avrprog_o, output_pdic_o, enable_output_pdic_o,
                                output_pdid_o, enable_output_pdid_o, output_nrst_o,
                                enable_output_nrst_o});
         end
         K_PWR: begin
            @(posedge clk_usb);                    // off bit registered here
            @(negedge clk_usb);
            check(name, s.exp, {11'd0, targetpower_off_o, targetio_oe_o});
         end
         default: begin
            seen_high = 1'b0;
            low_run = 0;
            repeat (8 * 16 + 40) begin
               @(negedge clk_usb);
               if (targetpower_off_o) seen_high = 1'b1;
               low_run = targetpower_off_o ? 0 : low_run + 1;
            end
            check(name, s.exp, {15'd0, seen_high && low_run >= 20});  // ramp then steady on
         end
      endcase
      if (s.kind != K_WR) begin
         tests++;
         $display("%s %s", (errors == e0) ? "ok  " : "FAIL", name);
      end
   endtask

   task automatic trigger_round(int i);
      int unsigned r;
      reg_byte_t src;
      reg_byte_t mod;
      io_vec_t lines;
      logic adv, dec, ana, exp_trig, exp_ext;
      int e0;
      e0 = errors;
      r = $urandom;
      src = r[7:0];
      src[7:6] = i[1:0];                           // sweep all four modes
      mod = {4'd0, r[11], i[4:2]};
      bus_write(ADDR_TRIGSRC, 7'd0, src);
      bus_write(ADDR_TRIGMOD, 7'd0, mod);
      r = $urandom;
      lines = r[3:0];
      {adv, dec, ana} = r[6:4];
      trigger_io_i <= lines;
      trigger_advio_i <= adv;
      trigger_decodedio_i <= dec;
      trigger_anapattern_i <= ana;
      @(posedge clk_usb);
      @(negedge clk_usb);
      exp_ext = comb_model(src[5:2], lines, src[7:6]);
      case (mod[2:0])
         3'd0: exp_trig = exp_ext;
         3'd1: exp_trig = adv;
         3'd2: exp_trig = ana;
         3'd3: exp_trig = dec;
         default: exp_trig = 1'b0;
      endcase
      check("trigger ext", {15'd0, exp_ext}, {15'd0, trigger_ext_o});
      check("trigger out", {15'd0, exp_trig}, {15'd0, trigger_o});
      check("trigger leds", {14'd0, src[0], mod[3]}, {14'd0, led_auxi_o, led_auxo_o});
      tests++;
      $display("%s trigger round %0d", (errors == e0) ? "ok  " : "FAIL", i);
   endtask

   initial begin
      void'($urandom(32'h19bf));
      reset = 1'b1;
      {reg_address_i, reg_bytecnt_i, reg_datai_i, reg_read_i, reg_write_i} = '0;
      {trigger_io_i, trigger_advio_i, trigger_decodedio_i, trigger_anapattern_i} = '0;
      {uart_tx_i, usi_out_i, targetio_i} = '0;

      add("reset trigsrc", K_RD, ADDR_TRIGSRC, 7'd0, 8'h00, 16'h0020);
      add("reset trigmod", K_RD, ADDR_TRIGMOD, 7'd0, 8'h00, 16'h0000);
      add("reset route b0", K_RD, ADDR_IOROUTE, 7'd0, 8'h00, 16'h0001);
      add("reset route b1", K_RD, ADDR_IOROUTE, 7'd1, 8'h00, 16'h0002);
      for (int b = 2; b < 8; b++)
         add($sformatf("reset route b%0d", b), K_RD, ADDR_IOROUTE, b[6:0], 8'h00, 16'h0000);
      add("", K_WR, ADDR_TRIGSRC, 7'd0, 8'hA5, 16'h0);
      add("", K_WR, ADDR_TRIGMOD, 7'd0, 8'h0B, 16'h0);
      for (int b = 0; b < 8; b++)
         add("", K_WR, ADDR_IOROUTE, b[6:0], 8'h11 * b[7:0] + 8'h0F, 16'h0);
      add("", K_WR, ADDR_IOROUTE, 7'd8, 8'hFF, 16'h0);
      add("readback trigsrc", K_RD, ADDR_TRIGSRC, 7'd0, 8'h00, 16'h00A5);
      add("readback trigmod", K_RD, ADDR_TRIGMOD, 7'd0, 8'h00, 16'h000B);
      for (int b = 0; b < 8; b++)
         add($sformatf("readback route b%0d", b), K_RD, ADDR_IOROUTE, b[6:0], 8'h00,
             {8'h00, 8'h11 * b[7:0] + 8'h0F});
      add("route byte 8 reads 0", K_RD, ADDR_IOROUTE, 7'd8, 8'h00, 16'h0000);
      add("unknown addr reads 0", K_RD, 6'd10, 7'd0, 8'h00, 16'h0000);
      add("", K_WR, ADDR_IOROUTE, 7'd5, 8'h00, 16'h0);   // power on, fast start off
      add("", K_WR, ADDR_IOROUTE, 7'd0, 8'h05, 16'h0);   // tx beats usio
      add("", K_WR, ADDR_IOROUTE, 7'd1, 8'h04, 16'h0);
      add("", K_WR, ADDR_IOROUTE, 7'd2, 8'h10, 16'h0);
      add("", K_WR, ADDR_IOROUTE, 7'd3, 8'hC0, 16'h0);
      add("drive tx1 usi0", K_IO, 6'd0, 7'd0, 8'h01, 16'h03F9);
      add("drive tx0 usi1", K_IO, 6'd0, 7'd0, 8'h02, 16'h03BA);
      add("", K_WR, ADDR_IOROUTE, 7'd2, 8'h20, 16'h0);
      add("line3 tx open collector", K_IO, 6'd0, 7'd0, 8'h02, 16'h03FA);
      add("", K_WR, ADDR_IOROUTE, 7'd3, 8'h40, 16'h0);
      add("val without en undriven", K_IO, 6'd0, 7'd0, 8'h02, 16'h0372);
      add("", K_WR, ADDR_IOROUTE, 7'd0, 8'h0A, 16'h0);
      add("", K_WR, ADDR_IOROUTE, 7'd1, 8'h0A, 16'h0);
      add("", K_WR, ADDR_IOROUTE, 7'd2, 8'h08, 16'h0);
      add("", K_WR, ADDR_IOROUTE, 7'd3, 8'h02, 16'h0);
      add("steer line1 low", K_IO, 6'd0, 7'd0, 8'hE0, 16'h0000);
      add("steer line1 high", K_IO, 6'd0, 7'd0, 8'h10, 16'h0300);
      add("", K_WR, ADDR_IOROUTE, 7'd0, 8'h00, 16'h0);
      add("steer line2 low", K_IO, 6'd0, 7'd0, 8'hD0, 16'h0000);
      add("steer line2 high", K_IO, 6'd0, 7'd0, 8'h20, 16'h0300);
      add("", K_WR, ADDR_IOROUTE, 7'd1, 8'h00, 16'h0);
      add("steer rx4 usi3", K_IO, 6'd0, 7'd0, 8'h80, 16'h0100);
      add("steer rx4 usi3 swap", K_IO, 6'd0, 7'd0, 8'h40, 16'h0200);
      add("pad snapshot", K_RD, ADDR_IOREAD, 7'd0, 8'h00, 16'h0004);
      add("", K_WR, ADDR_IOROUTE, 7'd6, 8'h2A, 16'h0);
      add("", K_WR, ADDR_IOROUTE, 7'd5, 8'h01, 16'h0);
      add("prog pin levels", K_PIN, 6'd0, 7'd0, 8'h00, 16'h006A);
      add("", K_WR, ADDR_IOROUTE, 7'd6, 8'h15, 16'h0);
      add("", K_WR, ADDR_IOROUTE, 7'd5, 8'h00, 16'h0);
      add("prog pin enables", K_PIN, 6'd0, 7'd0, 8'h00, 16'h0015);
      add("", K_WR, ADDR_IOROUTE, 7'd3, 8'hC0, 16'h0);
      add("", K_WR, ADDR_IOROUTE, 7'd5, 8'h02, 16'h0);
      add("power off high-z", K_PWR, 6'd0, 7'd0, 8'h00, 16'h0010);
      add("", K_WR, ADDR_IOROUTE, 7'd5, 8'h04, 16'h0);
      add("fast start on", K_PWR, 6'd0, 7'd0, 8'h00, 16'h0008);
      add("", K_WR, ADDR_IOROUTE, 7'd5, 8'h02, 16'h0);
      add("power off again", K_PWR, 6'd0, 7'd0, 8'h00, 16'h0010);
      add("", K_WR, ADDR_IOROUTE, 7'd5, 8'h00, 16'h0);
      add("soft start ramp", K_RAMP, 6'd0, 7'd0, 8'h00, 16'h0001);
      cycle_limit = 16 + (steps.size() + 2 * N_TRIG) * 4 + 8 * 16 + 200;

      repeat (16) @(posedge clk_usb);
      reset <= 1'b0;
      foreach (steps[i]) apply(steps[i], names[i]);
      for (int i = 0; i < N_TRIG; i++) trigger_round(i);

      $display("%0d tests, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* verilog.f */
cw_pkg.sv
cw_cfg_if.sv
cw_reg_file.sv
cw_trigger_mux.sv
cw_io_router.sv
cw_target_power.sv
cw_target_ctrl.sv
cw_target_ctrl_sva.sv
tb_cw_target_ctrl.sv
